//--- source/rv_decode_pkg.sv
package rv_decode_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // Major opcodes, bits 6..0 of the instruction
    typedef enum logic [6:0] {
        op_exe    = 7'b0110011,
        op_exei   = 7'b0010011,
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111
    } opcode_t;

    typedef enum logic [4:0] {
        ex_nop,                     // Must stay zero for the bubble
        ex_add,
        ex_sub,
        ex_xor,
        ex_or,
        ex_and,
        ex_sll,
        ex_srl,
        ex_sra,
        ex_slt,
        ex_sltu,
        ex_lb,
        ex_lh,
        ex_lw,
        ex_lbu,
        ex_lhu,
        ex_sb,
        ex_sh,
        ex_sw,
        ex_beq,
        ex_bne,
        ex_blt,
        ex_bge,
        ex_bltu,
        ex_bgeu,
        ex_jal,
        ex_jalr,
        ex_auipc
    } aluop_t;

    typedef enum logic [2:0] {
        res_nop,
        res_logic,
        res_shift,
        res_arith,
        res_ld_st,
        res_jal
    } alusel_t;

    typedef enum logic [2:0] {
        imm_none,
        imm_i,
        imm_i_shamt,
        imm_s,
        imm_b,
        imm_u,
        imm_j
    } imm_fmt_t;

    localparam logic [6:0] func7_base = 7'b0000000;
    localparam logic [6:0] func7_alt  = 7'b0100000;   // SUB and SRA

endpackage

//--- source/imm_gen.sv
`timescale 1ns/1ps

module imm_gen (
    input  logic [rv_decode_pkg::xlen-1:0] inst,
    input  rv_decode_pkg::imm_fmt_t        imm_fmt,
    output logic [rv_decode_pkg::xlen-1:0] imm
);

    localparam int xlen = rv_decode_pkg::xlen;

    logic sign;

    assign sign = inst[31];

    always_comb begin
        case (imm_fmt)
            rv_decode_pkg::imm_i: begin
                imm = {{(xlen-12){sign}}, inst[31:20]};
            end
            rv_decode_pkg::imm_i_shamt: begin
                imm = {{(xlen-5){1'b0}}, inst[24:20]};     // Shift amount only
            end
            rv_decode_pkg::imm_s: begin
                imm = {{(xlen-12){sign}}, inst[31:25], inst[11:7]};
            end
            rv_decode_pkg::imm_b: begin
                imm = {{(xlen-12){sign}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            rv_decode_pkg::imm_u: begin
                imm = {inst[31:12], 12'b0};
            end
            rv_decode_pkg::imm_j: begin
                // Scrambled J layout, bit 0 implied
                imm = {{(xlen-20){sign}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

//--- source/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    input  logic [6:0]               opcode,
    input  logic [2:0]               func3,
    input  logic [6:0]               func7,
    output rv_decode_pkg::aluop_t    aluop,
    output rv_decode_pkg::alusel_t   alusel,
    output rv_decode_pkg::imm_fmt_t  imm_fmt,
    output logic                     rd_enable,
    output logic                     r1_read_enable,
    output logic                     r2_read_enable,
    output logic                     use_imm
);

    rv_decode_pkg::aluop_t  f3_aluop;
    rv_decode_pkg::alusel_t f3_alusel;
    logic                   alt_f7;
    logic                   r_ok;
    logic                   i_ok;
    logic                   is_shift;

    assign alt_f7   = (func7 == rv_decode_pkg::func7_alt);
    assign is_shift = (func3 == 3'b001) || (func3 == 3'b101);

    // Register form: base func7 everywhere, alt only for SUB and SRA
    assign r_ok = (func7 == rv_decode_pkg::func7_base) ||
                  (alt_f7 && (func3 == 3'b000 || func3 == 3'b101));

    // Immediate form: func7 only matters for the shifts
    assign i_ok = !is_shift || (func7 == rv_decode_pkg::func7_base) ||
                  (alt_f7 && func3 == 3'b101);

    // ALU function shared by register and immediate forms
    always_comb begin
        case (func3)
            3'b000: begin
                f3_aluop  = rv_decode_pkg::ex_add;
                f3_alusel = rv_decode_pkg::res_arith;
            end
            3'b001: begin
                f3_aluop  = rv_decode_pkg::ex_sll;
                f3_alusel = rv_decode_pkg::res_shift;
            end
            3'b010: begin
                f3_aluop  = rv_decode_pkg::ex_slt;
                f3_alusel = rv_decode_pkg::res_arith;
            end
            3'b011: begin
                f3_aluop  = rv_decode_pkg::ex_sltu;
                f3_alusel = rv_decode_pkg::res_arith;
            end
            3'b100: begin
                f3_aluop  = rv_decode_pkg::ex_xor;
                f3_alusel = rv_decode_pkg::res_logic;
            end
            3'b101: begin
                f3_aluop  = alt_f7 ? rv_decode_pkg::ex_sra : rv_decode_pkg::ex_srl;
                f3_alusel = rv_decode_pkg::res_shift;
            end
            3'b110: begin
                f3_aluop  = rv_decode_pkg::ex_or;
                f3_alusel = rv_decode_pkg::res_logic;
            end
            default: begin
                f3_aluop  = rv_decode_pkg::ex_and;
                f3_alusel = rv_decode_pkg::res_logic;
            end
        endcase
    end

    always_comb begin
        aluop          = rv_decode_pkg::ex_nop;
        alusel         = rv_decode_pkg::res_nop;
        imm_fmt        = rv_decode_pkg::imm_none;
        rd_enable      = 1'b0;
        r1_read_enable = 1'b0;
        r2_read_enable = 1'b0;
        use_imm        = 1'b0;
        case (opcode)
            rv_decode_pkg::op_exe: begin
                if (r_ok) begin
                    aluop          = (alt_f7 && func3 == 3'b000) ? rv_decode_pkg::ex_sub : f3_aluop;
                    alusel         = f3_alusel;
                    rd_enable      = 1'b1;
                    r1_read_enable = 1'b1;
                    r2_read_enable = 1'b1;
                end
            end
            rv_decode_pkg::op_exei: begin
                if (i_ok) begin
                    aluop          = f3_aluop;
                    alusel         = f3_alusel;
                    imm_fmt        = is_shift ? rv_decode_pkg::imm_i_shamt : rv_decode_pkg::imm_i;
                    rd_enable      = 1'b1;
                    r1_read_enable = 1'b1;
                    use_imm        = 1'b1;
                end
            end
            rv_decode_pkg::op_lui: begin
                aluop     = rv_decode_pkg::ex_or;          // x0 | imm
                alusel    = rv_decode_pkg::res_logic;
                imm_fmt   = rv_decode_pkg::imm_u;
                rd_enable = 1'b1;
                use_imm   = 1'b1;
            end
            rv_decode_pkg::op_auipc: begin
                aluop     = rv_decode_pkg::ex_auipc;
                alusel    = rv_decode_pkg::res_arith;
                imm_fmt   = rv_decode_pkg::imm_u;
                rd_enable = 1'b1;
            end
            rv_decode_pkg::op_load: begin
                if (func3 != 3'b011 && func3[2:1] != 2'b11) begin
                    case (func3)
                        3'b000:  aluop = rv_decode_pkg::ex_lb;
                        3'b001:  aluop = rv_decode_pkg::ex_lh;
                        3'b010:  aluop = rv_decode_pkg::ex_lw;
                        3'b100:  aluop = rv_decode_pkg::ex_lbu;
                        default: aluop = rv_decode_pkg::ex_lhu;
                    endcase
                    alusel         = rv_decode_pkg::res_ld_st;
                    imm_fmt        = rv_decode_pkg::imm_i;  // Offset rides in imm
                    rd_enable      = 1'b1;
                    r1_read_enable = 1'b1;
                end
            end
            rv_decode_pkg::op_store: begin
                if (func3 == 3'b000 || func3 == 3'b001 || func3 == 3'b010) begin
                    case (func3)
                        3'b000:  aluop = rv_decode_pkg::ex_sb;
                        3'b001:  aluop = rv_decode_pkg::ex_sh;
                        default: aluop = rv_decode_pkg::ex_sw;
                    endcase
                    alusel         = rv_decode_pkg::res_ld_st;
                    imm_fmt        = rv_decode_pkg::imm_s;
                    r1_read_enable = 1'b1;
                    r2_read_enable = 1'b1;
                end
            end
            rv_decode_pkg::op_branch: begin
                if (func3[2:1] != 2'b01) begin
                    case (func3)
                        3'b000:  aluop = rv_decode_pkg::ex_beq;
                        3'b001:  aluop = rv_decode_pkg::ex_bne;
                        3'b100:  aluop = rv_decode_pkg::ex_blt;
                        3'b101:  aluop = rv_decode_pkg::ex_bge;
                        3'b110:  aluop = rv_decode_pkg::ex_bltu;
                        default: aluop = rv_decode_pkg::ex_bgeu;
                    endcase
                    imm_fmt        = rv_decode_pkg::imm_b;  // No result, alusel stays nop
                    r1_read_enable = 1'b1;
                    r2_read_enable = 1'b1;
                end
            end
            rv_decode_pkg::op_jal: begin
                aluop     = rv_decode_pkg::ex_jal;
                alusel    = rv_decode_pkg::res_jal;
                imm_fmt   = rv_decode_pkg::imm_j;
                rd_enable = 1'b1;
            end
            rv_decode_pkg::op_jalr: begin
                if (func3 == 3'b000) begin
                    aluop          = rv_decode_pkg::ex_jalr;
                    alusel         = rv_decode_pkg::res_jal;
                    imm_fmt        = rv_decode_pkg::imm_i;
                    rd_enable      = 1'b1;
                    r1_read_enable = 1'b1;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

//--- source/operand_forward.sv
`timescale 1ns/1ps

module operand_forward (
    input  logic [rv_decode_pkg::reg_addr_w-1:0] read_addr,
    input  logic                                 read_enable,
    input  logic [rv_decode_pkg::xlen-1:0]       reg_data,
    input  logic                                 ex_wb_flag,
    input  logic [rv_decode_pkg::reg_addr_w-1:0] ex_wb_addr,
    input  logic [rv_decode_pkg::xlen-1:0]       ex_forward,
    input  logic                                 mem_wb_flag,
    input  logic [rv_decode_pkg::reg_addr_w-1:0] mem_wb_addr,
    input  logic [rv_decode_pkg::xlen-1:0]       mem_forward,
    output logic [rv_decode_pkg::xlen-1:0]       operand
);

    logic ex_hit;
    logic mem_hit;

    assign ex_hit  = ex_wb_flag && (ex_wb_addr == read_addr);
    assign mem_hit = mem_wb_flag && (mem_wb_addr == read_addr);

    always_comb begin
        if (!read_enable) begin
            operand = '0;
        end else if (read_addr == '0) begin
            operand = reg_data;                   // x0 is never forwarded
        end else if (ex_hit) begin
            operand = ex_forward;                 // Youngest result wins
        end else if (mem_hit) begin
            operand = mem_forward;
        end else begin
            operand = reg_data;
        end
    end

endmodule

//--- source/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [rv_decode_pkg::xlen-1:0]       pc_i,
    input  logic [rv_decode_pkg::xlen-1:0]       inst,
    input  logic [rv_decode_pkg::xlen-1:0]       r1_data,
    input  logic [rv_decode_pkg::xlen-1:0]       r2_data,
    input  logic                                 ld_flag,
    input  logic                                 ex_wb_flag,
    input  logic [rv_decode_pkg::reg_addr_w-1:0] ex_wb_addr,
    input  logic [rv_decode_pkg::xlen-1:0]       ex_forward,
    input  logic                                 mem_wb_flag,
    input  logic [rv_decode_pkg::reg_addr_w-1:0] mem_wb_addr,
    input  logic [rv_decode_pkg::xlen-1:0]       mem_forward,
    output logic [rv_decode_pkg::reg_addr_w-1:0] r1_addr,
    output logic                                 r1_read_enable,
    output logic [rv_decode_pkg::reg_addr_w-1:0] r2_addr,
    output logic                                 r2_read_enable,
    output logic [rv_decode_pkg::xlen-1:0]       pc_o,
    output logic [rv_decode_pkg::xlen-1:0]       r1,
    output logic [rv_decode_pkg::xlen-1:0]       r2,
    output logic [rv_decode_pkg::xlen-1:0]       imm,
    output logic [rv_decode_pkg::reg_addr_w-1:0] rd,
    output logic                                 rd_enable,
    output rv_decode_pkg::aluop_t                aluop,
    output rv_decode_pkg::alusel_t               alusel,
    output logic                                 id_stall
);

    rv_decode_pkg::aluop_t       dec_aluop;
    rv_decode_pkg::alusel_t      dec_alusel;
    rv_decode_pkg::imm_fmt_t     dec_imm_fmt;
    logic                        dec_rd_enable;
    logic                        use_imm;
    logic [rv_decode_pkg::xlen-1:0] imm_val;
    logic [rv_decode_pkg::xlen-1:0] op1;
    logic [rv_decode_pkg::xlen-1:0] fwd_rs2;
    logic [rv_decode_pkg::xlen-1:0] op2;
    logic                        hazard_rs1;
    logic                        hazard_rs2;

    assign r1_addr = inst[19:15];
    assign r2_addr = inst[24:20];

    inst_decoder u_dec (
        .opcode         (inst[6:0]),
        .func3          (inst[14:12]),
        .func7          (inst[31:25]),
        .aluop          (dec_aluop),
        .alusel         (dec_alusel),
        .imm_fmt        (dec_imm_fmt),
        .rd_enable      (dec_rd_enable),
        .r1_read_enable (r1_read_enable),
        .r2_read_enable (r2_read_enable),
        .use_imm        (use_imm)
    );

    imm_gen u_imm (
        .inst    (inst),
        .imm_fmt (dec_imm_fmt),
        .imm     (imm_val)
    );

    operand_forward fwd_rs1_i (
        .read_addr   (r1_addr),
        .read_enable (r1_read_enable),
        .reg_data    (r1_data),
        .ex_wb_flag  (ex_wb_flag),
        .ex_wb_addr  (ex_wb_addr),
        .ex_forward  (ex_forward),
        .mem_wb_flag (mem_wb_flag),
        .mem_wb_addr (mem_wb_addr),
        .mem_forward (mem_forward),
        .operand     (op1)
    );

    operand_forward fwd_rs2_i (
        .read_addr   (r2_addr),
        .read_enable (r2_read_enable),
        .reg_data    (r2_data),
        .ex_wb_flag  (ex_wb_flag),
        .ex_wb_addr  (ex_wb_addr),
        .ex_forward  (ex_forward),
        .mem_wb_flag (mem_wb_flag),
        .mem_wb_addr (mem_wb_addr),
        .mem_forward (mem_forward),
        .operand     (fwd_rs2)
    );

    assign op2 = r2_read_enable ? fwd_rs2 : (use_imm ? imm_val : '0);

    // Load in EX cannot forward yet, so hold decode one cycle
    assign hazard_rs1 = r1_read_enable && (ex_wb_addr == r1_addr);
    assign hazard_rs2 = r2_read_enable && (ex_wb_addr == r2_addr);
    assign id_stall   = ld_flag && ex_wb_flag && (ex_wb_addr != '0) &&
                        (hazard_rs1 || hazard_rs2);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_o      <= '0;
            r1        <= '0;
            r2        <= '0;
            imm       <= '0;
            rd        <= '0;
            rd_enable <= 1'b0;
            aluop     <= rv_decode_pkg::ex_nop;
            alusel    <= rv_decode_pkg::res_nop;
        end else if (id_stall) begin
            pc_o      <= pc_i;
            r1        <= '0;                       // Bubble into EX
            r2        <= '0;
            imm       <= '0;
            rd        <= '0;
            rd_enable <= 1'b0;
            aluop     <= rv_decode_pkg::ex_nop;
            alusel    <= rv_decode_pkg::res_nop;
        end else begin
            pc_o      <= pc_i;
            r1        <= op1;
            r2        <= op2;
            imm       <= imm_val;
            rd        <= inst[11:7];
            rd_enable <= dec_rd_enable;
            aluop     <= dec_aluop;
            alusel    <= dec_alusel;
        end
    end

endmodule

//--- tests/decode_checker.sv
`timescale 1ns/1ps

module decode_checker (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [rv_decode_pkg::xlen-1:0]       pc_i,
    input  logic [rv_decode_pkg::xlen-1:0]       inst,
    input  logic [rv_decode_pkg::xlen-1:0]       r1_data,
    input  logic [rv_decode_pkg::xlen-1:0]       r2_data,
    input  logic                                 ld_flag,
    input  logic                                 ex_wb_flag,
    input  logic [rv_decode_pkg::reg_addr_w-1:0] ex_wb_addr,
    input  logic [rv_decode_pkg::xlen-1:0]       ex_forward,
    input  logic                                 mem_wb_flag,
    input  logic [rv_decode_pkg::reg_addr_w-1:0] mem_wb_addr,
    input  logic [rv_decode_pkg::xlen-1:0]       mem_forward,
    input  logic [rv_decode_pkg::reg_addr_w-1:0] r1_addr,
    input  logic                                 r1_read_enable,
    input  logic [rv_decode_pkg::reg_addr_w-1:0] r2_addr,
    input  logic                                 r2_read_enable,
    input  logic [rv_decode_pkg::xlen-1:0]       pc_o,
    input  logic [rv_decode_pkg::xlen-1:0]       r1,
    input  logic [rv_decode_pkg::xlen-1:0]       r2,
    input  logic [rv_decode_pkg::xlen-1:0]       imm,
    input  logic [rv_decode_pkg::reg_addr_w-1:0] rd,
    input  logic                                 rd_enable,
    input  rv_decode_pkg::aluop_t                aluop,
    input  rv_decode_pkg::alusel_t               alusel,
    input  logic                                 id_stall,
    output int                                   error_count,
    output int                                   check_count
);

    int errors = 0;
    int checks = 0;
    logic ready = 1'b0;                // Next-state model valid
    logic armed = 1'b0;                // Expected outputs valid
    rv_decode_pkg::aluop_t d_op;
    logic d_wr;
    logic d_rd1;
    logic d_rd2;
    logic d_uimm;
    logic d_stall;
    logic [31:0] d_imm;
    logic [31:0] nxt_pc;
    logic [31:0] nxt_r1;
    logic [31:0] nxt_r2;
    logic [31:0] nxt_imm;
    logic [4:0] nxt_rd;
    logic nxt_wr;
    rv_decode_pkg::aluop_t nxt_op;
    rv_decode_pkg::alusel_t nxt_sel;
    logic [31:0] exp_pc;
    logic [31:0] exp_r1;
    logic [31:0] exp_r2;
    logic [31:0] exp_imm;
    logic [4:0] exp_rd;
    logic exp_wr;
    rv_decode_pkg::aluop_t exp_op;
    rv_decode_pkg::alusel_t exp_sel;

    assign error_count = errors;
    assign check_count = checks;

    function automatic rv_decode_pkg::aluop_t alu_of(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0:    return alt ? rv_decode_pkg::ex_sub : rv_decode_pkg::ex_add;
            3'd1:    return rv_decode_pkg::ex_sll;
            3'd2:    return rv_decode_pkg::ex_slt;
            3'd3:    return rv_decode_pkg::ex_sltu;
            3'd4:    return rv_decode_pkg::ex_xor;
            3'd5:    return alt ? rv_decode_pkg::ex_sra : rv_decode_pkg::ex_srl;
            3'd6:    return rv_decode_pkg::ex_or;
            default: return rv_decode_pkg::ex_and;
        endcase
    endfunction

    // Result class follows from the operation alone
    function automatic rv_decode_pkg::alusel_t sel_of(input rv_decode_pkg::aluop_t op);
        case (op)
            rv_decode_pkg::ex_add, rv_decode_pkg::ex_sub, rv_decode_pkg::ex_slt,
            rv_decode_pkg::ex_sltu, rv_decode_pkg::ex_auipc: return rv_decode_pkg::res_arith;
            rv_decode_pkg::ex_xor, rv_decode_pkg::ex_or,
            rv_decode_pkg::ex_and:                           return rv_decode_pkg::res_logic;
            rv_decode_pkg::ex_sll, rv_decode_pkg::ex_srl,
            rv_decode_pkg::ex_sra:                           return rv_decode_pkg::res_shift;
            rv_decode_pkg::ex_lb, rv_decode_pkg::ex_lh, rv_decode_pkg::ex_lw,
            rv_decode_pkg::ex_lbu, rv_decode_pkg::ex_lhu, rv_decode_pkg::ex_sb,
            rv_decode_pkg::ex_sh, rv_decode_pkg::ex_sw:      return rv_decode_pkg::res_ld_st;
            rv_decode_pkg::ex_jal, rv_decode_pkg::ex_jalr:   return rv_decode_pkg::res_jal;
            default:                                         return rv_decode_pkg::res_nop;
        endcase
    endfunction

    function automatic logic [31:0] fwd_model(input logic [4:0] a, input logic en,
                                              input logic [31:0] d);
        if (!en) begin
            return 32'd0;
        end
        if (a == 5'd0) begin
            return d;
        end
        if (ex_wb_flag && ex_wb_addr == a) begin
            return ex_forward;
        end
        if (mem_wb_flag && mem_wb_addr == a) begin
            return mem_forward;
        end
        return d;
    endfunction

    task automatic model_decode(input logic [31:0] w, output rv_decode_pkg::aluop_t op,
                                output logic wr, output logic rd1, output logic rd2,
                                output logic uimm, output logic [31:0] immv);
        logic [2:0] f3;
        logic [6:0] f7;
        logic [31:0] i_imm;
        logic [31:0] s_imm;
        logic [31:0] b_imm;
        logic [31:0] j_imm;
        logic [31:0] u_imm;
        f3 = w[14:12];
        f7 = w[31:25];
        i_imm = $signed(w) >>> 20;
        s_imm = $signed({w[31:25], w[11:7], 20'b0}) >>> 20;
        b_imm = $signed({w[31], w[7], w[30:25], w[11:8], 1'b0, 19'b0}) >>> 19;
        j_imm = $signed({w[31], w[19:12], w[20], w[30:21], 1'b0, 11'b0}) >>> 11;
        u_imm = {w[31:12], 12'b0};
        op = rv_decode_pkg::ex_nop;
        wr = 1'b0;
        rd1 = 1'b0;
        rd2 = 1'b0;
        uimm = 1'b0;
        immv = 32'd0;
        case (w[6:0])
            7'b0110011: begin
                if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
                    op = alu_of(f3, f7[5]);
                    {wr, rd1, rd2} = 3'b111;
                end
            end
            7'b0010011: begin
                if (f3[1:0] != 2'b01 || f7 == 7'h00 || (f7 == 7'h20 && f3 == 3'd5)) begin
                    op = alu_of(f3, f3 == 3'd5 && f7[5]);
                    {wr, rd1, uimm} = 3'b111;
                    immv = (f3[1:0] == 2'b01) ? {27'b0, w[24:20]} : i_imm;
                end
            end
            7'b0110111: begin
                op = rv_decode_pkg::ex_or;                 // rd = x0 | imm
                {wr, uimm} = 2'b11;
                immv = u_imm;
            end
            7'b0010111: begin
                op = rv_decode_pkg::ex_auipc;
                wr = 1'b1;
                immv = u_imm;
            end
            7'b0000011: begin
                case (f3)
                    3'd0:    op = rv_decode_pkg::ex_lb;
                    3'd1:    op = rv_decode_pkg::ex_lh;
                    3'd2:    op = rv_decode_pkg::ex_lw;
                    3'd4:    op = rv_decode_pkg::ex_lbu;
                    3'd5:    op = rv_decode_pkg::ex_lhu;
                    default: op = rv_decode_pkg::ex_nop;
                endcase
                if (op != rv_decode_pkg::ex_nop) begin
                    {wr, rd1} = 2'b11;
                    immv = i_imm;
                end
            end
            7'b0100011: begin
                case (f3)
                    3'd0:    op = rv_decode_pkg::ex_sb;
                    3'd1:    op = rv_decode_pkg::ex_sh;
                    3'd2:    op = rv_decode_pkg::ex_sw;
                    default: op = rv_decode_pkg::ex_nop;
                endcase
                if (op != rv_decode_pkg::ex_nop) begin
                    {rd1, rd2} = 2'b11;
                    immv = s_imm;
                end
            end
            7'b1100011: begin
                case (f3)
                    3'd0:    op = rv_decode_pkg::ex_beq;
                    3'd1:    op = rv_decode_pkg::ex_bne;
                    3'd4:    op = rv_decode_pkg::ex_blt;
                    3'd5:    op = rv_decode_pkg::ex_bge;
                    3'd6:    op = rv_decode_pkg::ex_bltu;
                    3'd7:    op = rv_decode_pkg::ex_bgeu;
                    default: op = rv_decode_pkg::ex_nop;
                endcase
                if (op != rv_decode_pkg::ex_nop) begin
                    {rd1, rd2} = 2'b11;
                    immv = b_imm;
                end
            end
            7'b1101111: begin
                op = rv_decode_pkg::ex_jal;
                wr = 1'b1;
                immv = j_imm;
            end
            7'b1100111: begin
                if (f3 == 3'd0) begin
                    op = rv_decode_pkg::ex_jalr;
                    {wr, rd1} = 2'b11;
                    immv = i_imm;
                end
            end
            default: begin
            end
        endcase
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL time %0t signal %s expected %h actual %h", $time, name,
                     expected, actual);
            errors = errors + 1;
        end
    endtask

    // Inputs settle by mid-cycle while registered outputs still hold the last edge
    always @(negedge clk) begin
        if (armed) begin
            check_value("pc_o", exp_pc, pc_o);
            check_value("r1", exp_r1, r1);
            check_value("r2", exp_r2, r2);
            check_value("imm", exp_imm, imm);
            check_value("rd", 32'(exp_rd), 32'(rd));
            check_value("rd_enable", 32'(exp_wr), 32'(rd_enable));
            check_value("aluop", 32'(exp_op), 32'(aluop));
            check_value("alusel", 32'(exp_sel), 32'(alusel));
            checks = checks + 1;
        end
        model_decode(inst, d_op, d_wr, d_rd1, d_rd2, d_uimm, d_imm);
        check_value("r1_addr", 32'(inst[19:15]), 32'(r1_addr));
        check_value("r2_addr", 32'(inst[24:20]), 32'(r2_addr));
        check_value("r1_read_enable", 32'(d_rd1), 32'(r1_read_enable));
        check_value("r2_read_enable", 32'(d_rd2), 32'(r2_read_enable));
        d_stall = ld_flag && ex_wb_flag && (ex_wb_addr != 5'd0) &&
                  ((d_rd1 && ex_wb_addr == inst[19:15]) || (d_rd2 && ex_wb_addr == inst[24:20]));
        check_value("id_stall", 32'(d_stall), 32'(id_stall));
        nxt_pc = rst ? 32'd0 : pc_i;
        if (rst || d_stall) begin
            nxt_r1 = 32'd0;
            nxt_r2 = 32'd0;
            nxt_imm = 32'd0;
            nxt_rd = 5'd0;
            nxt_wr = 1'b0;
            nxt_op = rv_decode_pkg::ex_nop;
        end else begin
            nxt_r1 = fwd_model(inst[19:15], d_rd1, r1_data);
            nxt_r2 = d_rd2 ? fwd_model(inst[24:20], 1'b1, r2_data) : (d_uimm ? d_imm : 32'd0);
            nxt_imm = d_imm;
            nxt_rd = inst[11:7];
            nxt_wr = d_wr;
            nxt_op = d_op;
        end
        nxt_sel = sel_of(nxt_op);
        ready = 1'b1;
    end

    always @(posedge clk) begin
        if (ready) begin
            exp_pc = nxt_pc;
            exp_r1 = nxt_r1;
            exp_r2 = nxt_r2;
            exp_imm = nxt_imm;
            exp_rd = nxt_rd;
            exp_wr = nxt_wr;
            exp_op = nxt_op;
            exp_sel = nxt_sel;
            armed = 1'b1;
        end
    end

endmodule

//--- tests/tb_decode_stage.sv
`timescale 1ns/1ps

module tb_decode_stage;

    localparam int n_inst       = 2000;
    localparam int reset_cycles = 5;
    localparam int cycle_limit  = n_inst + reset_cycles + 100;

    logic clk;
    logic rst;
    logic [31:0] pc_i;
    logic [31:0] inst;
    logic [31:0] r1_data;
    logic [31:0] r2_data;
    logic ld_flag;
    logic ex_wb_flag;
    logic [4:0] ex_wb_addr;
    logic [31:0] ex_forward;
    logic mem_wb_flag;
    logic [4:0] mem_wb_addr;
    logic [31:0] mem_forward;
    logic [4:0] r1_addr;
    logic r1_read_enable;
    logic [4:0] r2_addr;
    logic r2_read_enable;
    logic [31:0] pc_o;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] imm;
    logic [4:0] rd;
    logic rd_enable;
    rv_decode_pkg::aluop_t aluop;
    rv_decode_pkg::alusel_t alusel;
    logic id_stall;
    int error_count;
    int check_count;
    int cycles = 0;
    int accepted = 0;
    logic [31:0] lfsr_state = 32'd98451;

    decode_stage dut_i (.*);

    decode_checker chk_i (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32 22 2 1
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = 32'd0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    task automatic build_inst(output logic [31:0] word);
        logic [31:0] w;
        logic [31:0] b;
        take_bits(32, w);
        take_bits(4, b);
        case (b[3:0])
            4'd0, 4'd1, 4'd14: begin
                w[6:0] = 7'b0110011;
                w[31:25] = ((w[14:12] == 3'd0 || w[14:12] == 3'd5) && w[25]) ? 7'h20 : 7'h00;
            end
            4'd2, 4'd3, 4'd15: begin
                w[6:0] = 7'b0010011;
                if (w[13:12] == 2'b01) begin
                    w[31:25] = (w[14] && w[25]) ? 7'h20 : 7'h00;   // SRAI only
                end
            end
            4'd4: w[6:0] = 7'b0110111;
            4'd5: w[6:0] = 7'b0010111;
            4'd6, 4'd7: begin
                w[6:0] = 7'b0000011;
                take_bits(3, b);
                case (b[2:0])
                    3'd0:    w[14:12] = 3'd0;
                    3'd1:    w[14:12] = 3'd1;
                    3'd2:    w[14:12] = 3'd2;
                    3'd3:    w[14:12] = 3'd4;
                    default: w[14:12] = 3'd5;
                endcase
            end
            4'd8: begin
                w[6:0] = 7'b0100011;
                take_bits(2, b);
                w[14:12] = (b[1:0] == 2'd3) ? 3'd2 : {1'b0, b[1:0]};
            end
            4'd9, 4'd10: begin
                w[6:0] = 7'b1100011;
                if (w[14:13] == 2'b01) begin
                    w[14] = 1'b1;
                end
            end
            4'd11: w[6:0] = 7'b1101111;
            4'd12: begin
                w[6:0] = 7'b1100111;
                w[14:12] = 3'd0;
            end
            default: begin                     // Raw word that is mostly illegal
            end
        endcase
        word = w;
    endtask

    // Bias toward the sources of the current instruction
    task automatic pick_addr(input logic [31:0] word, output logic [4:0] addr);
        logic [31:0] b;
        take_bits(2, b);
        if (b[1:0] == 2'd0) begin
            addr = word[19:15];
        end else if (b[1:0] == 2'd1) begin
            addr = word[24:20];
        end else begin
            take_bits(5, b);
            addr = b[4:0];
        end
    endtask

    task automatic drive_inputs(input logic hold);
        logic [31:0] word;
        logic [31:0] b;
        logic [4:0] a;
        if (hold) begin
            word = inst;
        end else begin
            build_inst(word);
            inst <= word;
            pc_i <= pc_i + 32'd4;
        end
        take_bits(32, b);
        r1_data <= b;
        take_bits(32, b);
        r2_data <= b;
        take_bits(2, b);
        ex_wb_flag <= |b[1:0];
        pick_addr(word, a);
        ex_wb_addr <= a;
        take_bits(32, b);
        ex_forward <= b;
        take_bits(2, b);
        mem_wb_flag <= |b[1:0];
        pick_addr(word, a);
        mem_wb_addr <= a;
        take_bits(32, b);
        mem_forward <= b;
        take_bits(5, b);
        ld_flag <= !hold && (b[4:0] == 5'h1f);     // Bubble follows a stall
    endtask

    task automatic print_summary(input int timeouts);
        $display("checks %0d, value errors %0d, timeouts %0d", check_count, error_count,
                 timeouts);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: %0d instructions accepted after %0d cycles", accepted, cycles);
            print_summary(1);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        pc_i = 32'd0;
        inst = 32'd0;
        r1_data = 32'd0;
        r2_data = 32'd0;
        ld_flag = 1'b0;
        ex_wb_flag = 1'b0;
        ex_wb_addr = 5'd0;
        ex_forward = 32'd0;
        mem_wb_flag = 1'b0;
        mem_wb_addr = 5'd0;
        mem_forward = 32'd0;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
        drive_inputs(1'b0);
        while (accepted < n_inst) begin
            @(posedge clk);
            if (!id_stall) begin
                accepted = accepted + 1;
            end
            drive_inputs(id_stall);
        end
        @(negedge clk);                        // Last result compared on this edge
        #1;
        print_summary(0);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- list.f
source/rv_decode_pkg.sv
source/imm_gen.sv
source/inst_decoder.sv
source/operand_forward.sv
source/decode_stage.sv
tests/decode_checker.sv
tests/tb_decode_stage.sv

//--- run.sh
#!/usr/bin/env bash
# Build with Verilator, run, then scan the simulation log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_decode_stage -f list.f -o tb_sim > build.log 2>&1 \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    && ! grep -qF '** FAIL **' sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }
